// File: Bender.yml
package:
  name: dsi_packet_assembler

sources:
  - dsi_pkg.sv
  - dsi_ecc.sv
  - dsi_crc16.sv
  - packet_framer.sv
  - byte_repacker.sv
  - lane_slot.sv
  - lane_write_gate.sv
  - dsi_packet_assembler.sv
  - target: test
    files:
      - tb_dsi_packet_assembler.sv

// File: byte_repacker.sv
`timescale 1ns/10ps

module byte_repacker #(
    parameter int LANES = dsi_pkg::lane_count
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [2:0]           lines_number,
    input  logic                 word_valid,
    input  logic [31:0]          word_data,
    input  dsi_pkg::byte_count_t word_bytes,
    input  logic                 word_last,
    output logic                 word_take,
    input  logic                 slots_ready,
    output logic                 slot_load,
    output logic [LANES*8-1:0]   slot_byte,
    output dsi_pkg::lane_mask_t  slot_fill
);
    import dsi_pkg::*;

    logic [63:0] buf_q;  // byte 0 is the oldest
    logic [63:0] buf_d;
    logic [63:0] shifted;
    logic [63:0] placed;
    logic [3:0]  cnt_q;
    logic [3:0]  cnt_mid;
    logic        last_in_q;  // tail of a packet is in the buffer
    byte_count_t n_lanes;
    byte_count_t load_bytes;

    always_comb
    begin
        n_lanes = (lines_number == 3'd0) ? 3'd1 : lines_number;
        if (n_lanes > LANES)
            n_lanes = byte_count_t'(LANES);
    end

    assign word_take  = word_valid && (cnt_q <= 4'd4) && !last_in_q;
    assign load_bytes = (cnt_q >= {1'b0, n_lanes}) ? n_lanes : cnt_q[2:0];
    assign slot_load  = slots_ready && (cnt_q != 4'd0)
                        && (last_in_q || (cnt_q >= {1'b0, n_lanes}));
    assign slot_byte  = buf_q[LANES*8-1:0];
    assign cnt_mid    = cnt_q - (slot_load ? {1'b0, load_bytes} : 4'd0);

    always_comb
    begin
        shifted = slot_load ? (buf_q >> {load_bytes, 3'b000}) : buf_q;
        placed  = {32'h0, word_data} << {cnt_mid, 3'b000};
        for (int j = 0; j < 8; j++)
            buf_d[j*8 +: 8] = (word_take && (j >= cnt_mid)) ? placed[j*8 +: 8]
                                                             : shifted[j*8 +: 8];
        for (int k = 0; k < lane_count; k++)
            slot_fill[k] = (k < load_bytes);  // low lanes first
    end

    always_ff @(posedge clk)
    begin
        buf_q <= buf_d;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt_q     <= 4'd0;
            last_in_q <= 1'b0;
        end
        else
        begin
            cnt_q <= cnt_mid + (word_take ? {1'b0, word_bytes} : 4'd0);
            if (word_take && word_last)
                last_in_q <= 1'b1;
            else if (slot_load && last_in_q && (cnt_mid == 4'd0))
                last_in_q <= 1'b0;  // packet fully handed to the slots
        end
    end

endmodule

// File: dsi_crc16.sv
`timescale 1ns/10ps

module dsi_crc16 (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clear,
    input  dsi_pkg::lane_mask_t byte_valid,
    input  logic [31:0]         data,
    output logic [15:0]         crc
);
    import dsi_pkg::*;

    logic [15:0] crc_q;
    logic [15:0] crc_d;

    // one byte, lsb first
    function automatic logic [15:0] fold_byte(logic [15:0] c, logic [7:0] b);
        logic [15:0] r;
        r = c;
        for (int i = 0; i < 8; i++)
        begin
            if (r[0] ^ b[i])
                r = (r >> 1) ^ CRC_POLY_REFLECTED;
            else
                r = r >> 1;
        end
        return r;
    endfunction

    always_comb
    begin
        crc_d = crc_q;
        for (int k = 0; k < lane_count; k++)
        begin
            if (byte_valid[k])
                crc_d = fold_byte(crc_d, data[k*8 +: 8]);  // byte 0 first
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            crc_q <= CRC_INIT;
        else if (clear)
            crc_q <= CRC_INIT;
        else
            crc_q <= crc_d;
    end

    assign crc = crc_q;

endmodule

// File: dsi_ecc.sv
`timescale 1ns/10ps

module dsi_ecc (
    input  dsi_pkg::dsi_header_u header,
    output logic [7:0]           ecc
);

    // parity bit sets over d[23:0], d0 is the lsb of the data id byte
    localparam logic [23:0] P0_SET = 24'hF12CB7;  // d0-2,4,5,7,10,11,13,16,20-23
    localparam logic [23:0] P1_SET = 24'hF2555B;  // d0,1,3,4,6,8,10,12,14,17,20-23
    localparam logic [23:0] P2_SET = 24'h749A6D;  // d0,2,3,5,6,9,11,12,15,18,20-22
    localparam logic [23:0] P3_SET = 24'hB8E38E;  // d1-3,7-9,13-15,19-21,23
    localparam logic [23:0] P4_SET = 24'hDF03F0;  // d4-9,16-20,22,23
    localparam logic [23:0] P5_SET = 24'hEFFC00;  // d10-19,21-23

    logic [23:0] d;

    // byte order on the wire: data id, wc lsb, wc msb
    assign d = {header.short_h.data1, header.short_h.data0,
                header.short_h.vc, header.short_h.dt};

    assign ecc = {2'b00,
                  ^(d & P5_SET),
                  ^(d & P4_SET),
                  ^(d & P3_SET),
                  ^(d & P2_SET),
                  ^(d & P1_SET),
                  ^(d & P0_SET)};

endmodule

// File: dsi_packet_assembler.sv
`timescale 1ns/10ps

module dsi_packet_assembler #(
    parameter int LANES = dsi_pkg::lane_count
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [31:0]        usr_fifo_data,
    input  logic               usr_fifo_empty,
    output logic               usr_fifo_read,
    input  logic [2:0]         lines_number,
    output logic [LANES*8-1:0] lanes_fifo_data,
    output logic [LANES-1:0]   lanes_fifo_write,
    input  logic [LANES-1:0]   lanes_fifo_full
);
    import dsi_pkg::*;

    logic               word_valid;
    logic [31:0]        word_data;
    byte_count_t        word_bytes;
    logic               word_last;
    logic               word_take;
    logic               slots_ready;
    logic               slot_load;
    logic [LANES*8-1:0] slot_byte;
    lane_mask_t         slot_fill;
    logic [LANES-1:0]   slot_busy;
    lane_mask_t         busy_mask;
    lane_mask_t         full_mask;

    // unused upper lanes read as idle
    assign busy_mask = lane_mask_t'(slot_busy);
    assign full_mask = lane_mask_t'(lanes_fifo_full);

    packet_framer u_framer (
        .clk            (clk),
        .rst_n          (rst_n),
        .usr_fifo_data  (usr_fifo_data),
        .usr_fifo_empty (usr_fifo_empty),
        .usr_fifo_read  (usr_fifo_read),
        .word_valid     (word_valid),
        .word_data      (word_data),
        .word_bytes     (word_bytes),
        .word_last      (word_last),
        .word_take      (word_take)
    );

    byte_repacker #(.LANES(LANES)) u_repacker (
        .clk          (clk),
        .rst_n        (rst_n),
        .lines_number (lines_number),
        .word_valid   (word_valid),
        .word_data    (word_data),
        .word_bytes   (word_bytes),
        .word_last    (word_last),
        .word_take    (word_take),
        .slots_ready  (slots_ready),
        .slot_load    (slot_load),
        .slot_byte    (slot_byte),
        .slot_fill    (slot_fill)
    );

    for (genvar i = 0; i < LANES; i++)
    begin : g_lane
        lane_slot u_slot (
            .clk        (clk),
            .rst_n      (rst_n),
            .slot_load  (slot_load),
            .fill       (slot_fill[i]),
            .load_byte  (slot_byte[i*8 +: 8]),
            .lane_full  (lanes_fifo_full[i]),
            .lane_byte  (lanes_fifo_data[i*8 +: 8]),
            .lane_write (lanes_fifo_write[i]),
            .slot_busy  (slot_busy[i])
        );
    end

    lane_write_gate #(.LANES(LANES)) u_gate (
        .clk             (clk),
        .rst_n           (rst_n),
        .lines_number    (lines_number),
        .slot_busy       (busy_mask),
        .lanes_fifo_full (full_mask),
        .slots_ready     (slots_ready)
    );

endmodule

// File: dsi_pkg.sv
package dsi_pkg;

    localparam int lane_count = 4;  // widest lane configuration

    typedef logic [lane_count-1:0] lane_mask_t;
    typedef logic [2:0]            byte_count_t;  // 0..4 valid bytes in a word
    typedef logic [15:0]           word_count_t;
    typedef logic [5:0]            data_type_t;

    // header as it sits in bits 23:0 of the first user FIFO word
    typedef union packed
    {
        struct packed
        {
            logic [1:0]  vc;  // virtual channel, held at zero
            data_type_t  dt;
            word_count_t wc;
        } long_h;
        struct packed
        {
            logic [1:0]  vc;
            data_type_t  dt;
            logic [7:0]  data1;
            logic [7:0]  data0;
        } short_h;
    } dsi_header_u;

    localparam logic [15:0] CRC_INIT           = 16'hFFFF;
    localparam logic [15:0] CRC_POLY_REFLECTED = 16'h8408;

    // long when bit 3 is set and the low three bits are not all zero
    function automatic logic is_long_packet(data_type_t dt);
        return dt[3] && (dt[2:0] != 3'b000);
    endfunction

endpackage

// File: flist.f
dsi_pkg.sv
dsi_ecc.sv
dsi_crc16.sv
packet_framer.sv
byte_repacker.sv
lane_slot.sv
lane_write_gate.sv
dsi_packet_assembler.sv
tb_dsi_packet_assembler.sv

// File: lane_slot.sv
`timescale 1ns/10ps

module lane_slot (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       slot_load,
    input  logic       fill,
    input  logic [7:0] load_byte,
    input  logic       lane_full,
    output logic [7:0] lane_byte,
    output logic       lane_write,
    output logic       slot_busy
);

    logic [7:0] byte_q;
    logic       busy_q;

    assign lane_write = busy_q && !lane_full;
    assign lane_byte  = byte_q;
    assign slot_busy  = busy_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            busy_q <= 1'b0;
        else if (slot_load && fill)
            busy_q <= 1'b1;  // a new byte may follow the write directly
        else if (lane_write)
            busy_q <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (slot_load && fill)
            byte_q <= load_byte;
    end

endmodule

// File: lane_write_gate.sv
`timescale 1ns/10ps

module lane_write_gate #(
    parameter int LANES = dsi_pkg::lane_count
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [2:0]          lines_number,
    input  dsi_pkg::lane_mask_t slot_busy,
    input  dsi_pkg::lane_mask_t lanes_fifo_full,
    output logic                slots_ready
);
    import dsi_pkg::*;

    lane_mask_t active_q;

    // lane k is used when k < max(lines_number, 1), capped at LANES
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            active_q <= '0;
        else
            for (int k = 0; k < lane_count; k++)
                active_q[k] <= (k < LANES) && ((k < lines_number) || (k == 0));
    end

    // idle or emptying this cycle
    assign slots_ready = &(~active_q | ~slot_busy | ~lanes_fifo_full);

endmodule

// File: packet_framer.sv
`timescale 1ns/10ps

module packet_framer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [31:0]          usr_fifo_data,
    input  logic                 usr_fifo_empty,
    output logic                 usr_fifo_read,
    output logic                 word_valid,
    output logic [31:0]          word_data,
    output dsi_pkg::byte_count_t word_bytes,
    output logic                 word_last,
    input  logic                 word_take
);
    import dsi_pkg::*;

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_HEADER  = 2'd1;
    localparam logic [1:0] ST_PAYLOAD = 2'd2;
    localparam logic [1:0] ST_CRC     = 2'd3;

    logic [1:0]  state_q;
    logic [1:0]  state_d;
    logic        valid_d;
    dsi_header_u hdr_q;
    logic [31:0] data_q;
    byte_count_t bytes_q;
    word_count_t remain_q;  // payload bytes not yet fetched
    word_count_t rem_src;
    byte_count_t fetch_bytes;
    logic        fetch_hdr;
    logic        fetch_pay;
    logic        header_long;
    logic        xfer;
    lane_mask_t  pay_mask;
    logic [7:0]  ecc;
    logic [15:0] crc;

    assign header_long = is_long_packet(hdr_q.long_h.dt);
    assign xfer        = word_valid && word_take;
    assign rem_src     = (state_q == ST_HEADER) ? hdr_q.long_h.wc : remain_q;
    assign fetch_bytes = (rem_src > 16'd4) ? 3'd4 : rem_src[2:0];

    always_comb
    begin
        state_d   = state_q;
        valid_d   = word_valid;
        fetch_hdr = 1'b0;
        fetch_pay = 1'b0;
        case (state_q)
            ST_IDLE:
                if (!usr_fifo_empty)
                begin
                    fetch_hdr = 1'b1;
                    state_d   = ST_HEADER;
                    valid_d   = 1'b1;
                end
            ST_HEADER:
                if (xfer)
                begin
                    if (!header_long)
                    begin
                        fetch_hdr = !usr_fifo_empty;  // back to back short packets
                        state_d   = usr_fifo_empty ? ST_IDLE : ST_HEADER;
                        valid_d   = !usr_fifo_empty;
                    end
                    else if (hdr_q.long_h.wc == 16'd0)
                        state_d = ST_CRC;
                    else
                    begin
                        fetch_pay = !usr_fifo_empty;
                        state_d   = ST_PAYLOAD;
                        valid_d   = !usr_fifo_empty;
                    end
                end
            ST_PAYLOAD:
                if (!word_valid || word_take)
                begin
                    if (remain_q == 16'd0)
                        state_d = ST_CRC;  // last payload word leaves now
                    else
                    begin
                        fetch_pay = !usr_fifo_empty;
                        valid_d   = !usr_fifo_empty;
                    end
                end
            default:
                if (xfer)
                begin
                    fetch_hdr = !usr_fifo_empty;
                    state_d   = usr_fifo_empty ? ST_IDLE : ST_HEADER;
                    valid_d   = !usr_fifo_empty;
                end
        endcase
    end

    assign usr_fifo_read = fetch_hdr || fetch_pay;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q    <= ST_IDLE;
            word_valid <= 1'b0;
            remain_q   <= '0;
        end
        else
        begin
            state_q    <= state_d;
            word_valid <= valid_d;
            if (fetch_pay)
                remain_q <= rem_src - word_count_t'(fetch_bytes);
            else if (state_q == ST_HEADER)
                remain_q <= hdr_q.long_h.wc;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fetch_hdr)
            hdr_q <= {2'b00, usr_fifo_data[21:0]};
        if (fetch_pay)
        begin
            data_q  <= usr_fifo_data;
            bytes_q <= fetch_bytes;
        end
    end

    always_comb
    begin
        for (int k = 0; k < lane_count; k++)
            pay_mask[k] = (state_q == ST_PAYLOAD) && xfer && (k < bytes_q);
    end

    always_comb
    begin
        case (state_q)
            ST_HEADER:
            begin
                word_data  = {ecc, hdr_q.short_h.data1, hdr_q.short_h.data0,
                              hdr_q.short_h.vc, hdr_q.short_h.dt};
                word_bytes = 3'd4;
            end
            ST_PAYLOAD:
            begin
                word_data  = data_q;
                word_bytes = bytes_q;
            end
            ST_CRC:
            begin
                word_data  = {16'h0000, crc};  // crc low byte first
                word_bytes = 3'd2;
            end
            default:
            begin
                word_data  = 32'h0;
                word_bytes = 3'd0;
            end
        endcase
    end

    assign word_last = ((state_q == ST_HEADER) && !header_long) || (state_q == ST_CRC);

    dsi_ecc u_ecc (
        .header (hdr_q),
        .ecc    (ecc)
    );

    dsi_crc16 u_crc (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (fetch_hdr),
        .byte_valid (pay_mask),
        .data       (word_data),
        .crc        (crc)
    );

endmodule

// File: tb_dsi_packet_assembler.sv
`timescale 1ns/10ps

module tb_dsi_packet_assembler;
    import dsi_pkg::*;

    localparam int groups      = 10;
    localparam int packets     = 10;  // per group
    localparam int cycle_limit = 200 * groups * packets;

    logic                    clk;
    logic                    rst_n;
    logic [31:0]             usr_fifo_data;
    logic                    usr_fifo_empty;
    logic                    usr_fifo_read;
    logic [2:0]              lines_number;
    logic [lane_count*8-1:0] lanes_fifo_data;
    logic [lane_count-1:0]   lanes_fifo_write;
    logic [lane_count-1:0]   lanes_fifo_full;

    logic [31:0] pkt_state;    // stream for packet contents
    logic [31:0] noise_state;  // stream for full and empty noise
    logic [31:0] fifo_q[$];    // user FIFO model
    logic [7:0]  exp_q[lane_count][$];
    logic        stress;
    int          cycles = 0;

    dsi_packet_assembler #(.LANES(lane_count)) u_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .usr_fifo_data    (usr_fifo_data),
        .usr_fifo_empty   (usr_fifo_empty),
        .usr_fifo_read    (usr_fifo_read),
        .lines_number     (lines_number),
        .lanes_fifo_data  (lanes_fifo_data),
        .lanes_fifo_write (lanes_fifo_write),
        .lanes_fifo_full  (lanes_fifo_full)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // dsi hamming parity with d[7:0] as the data id
    function automatic logic [7:0] ecc_of(input logic [23:0] d);
        logic [7:0] p;
        p[0] = d[0]^d[1]^d[2]^d[4]^d[5]^d[7]^d[10]^d[11]^d[13]^d[16]^d[20]^d[21]^d[22]^d[23];
        p[1] = d[0]^d[1]^d[3]^d[4]^d[6]^d[8]^d[10]^d[12]^d[14]^d[17]^d[20]^d[21]^d[22]^d[23];
        p[2] = d[0]^d[2]^d[3]^d[5]^d[6]^d[9]^d[11]^d[12]^d[15]^d[18]^d[20]^d[21]^d[22];
        p[3] = d[1]^d[2]^d[3]^d[7]^d[8]^d[9]^d[13]^d[14]^d[15]^d[19]^d[20]^d[21]^d[23];
        p[4] = d[4]^d[5]^d[6]^d[7]^d[8]^d[9]^d[16]^d[17]^d[18]^d[19]^d[20]^d[22]^d[23];
        p[5] = d[10]^d[11]^d[12]^d[13]^d[14]^d[15]^d[16]^d[17]^d[18]^d[19]^d[21]^d[22]^d[23];
        p[7:6] = 2'b00;
        return p;
    endfunction

    function automatic logic [15:0] crc_step(input logic [15:0] c, input logic [7:0] b);
        logic [15:0] r;
        logic        fb;
        r = c;
        for (int i = 0; i < 8; i++)
        begin
            fb = r[0] ^ b[i];  // lsb first
            r  = {1'b0, r[15:1]} ^ (fb ? 16'h8408 : 16'h0000);
        end
        return r;
    endfunction

    function automatic logic work_left();
        logic left;
        left = (fifo_q.size() != 0);
        for (int i = 0; i < lane_count; i++)
            left = left || (exp_q[i].size() != 0);
        return left;
    endfunction

    task automatic stop_failed();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] want, input string what);
        if (got !== want)
        begin
            $display("ERR %0t: %s, got %0h expected %0h", $time, what, got, want);
            stop_failed();
        end
    endtask

    // user FIFO words plus the expected byte stream split round robin from lane 0
    task automatic queue_packet(input logic [5:0] dt, input logic [15:0] field, input int used);
        logic [7:0]  stream[$];
        logic [7:0]  id;
        logic [15:0] crc;
        logic [31:0] word;
        logic        long_pkt;
        id       = {2'b00, dt};
        long_pkt = dt[3] && (dt[2:0] != 3'b000);
        if (long_pkt)
            field = field % 16'd41;  // payload of 0 to 40 bytes
        fifo_q.push_back({8'h00, id, field});
        stream.push_back(id);
        stream.push_back(field[7:0]);
        stream.push_back(field[15:8]);
        stream.push_back(ecc_of({field, id}));
        if (long_pkt)
        begin
            crc  = 16'hFFFF;
            word = 32'h0;
            for (int i = 0; i < int'(field); i++)
            begin
                if (i % 4 == 0)
                begin
                    pkt_state = lcg_step(pkt_state);
                    word      = pkt_state;  // padding beyond the word count stays random
                end
                pkt_state             = lcg_step(pkt_state);
                word[(i % 4)*8 +: 8]  = pkt_state[23:16];
                crc                   = crc_step(crc, pkt_state[23:16]);
                stream.push_back(pkt_state[23:16]);
                if ((i % 4 == 3) || (i == int'(field) - 1))
                    fifo_q.push_back(word);
            end
            stream.push_back(crc[7:0]);
            stream.push_back(crc[15:8]);
        end
        for (int i = 0; i < stream.size(); i++)
            exp_q[i % used].push_back(stream[i]);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // user FIFO and lane full drive
    initial
    begin
        usr_fifo_data   = 32'h0;
        usr_fifo_empty  = 1'b1;
        lanes_fifo_full = '0;
        noise_state     = 32'd57;
        forever
        begin
            @(posedge clk);
            if (usr_fifo_read && (fifo_q.size() != 0))
                void'(fifo_q.pop_front());
            noise_state = lcg_step(noise_state);
            lanes_fifo_full <= stress ? (noise_state[19:16] & noise_state[23:20]) : '0;
            usr_fifo_empty  <= (fifo_q.size() == 0)
                               || (stress && (noise_state[26:25] == 2'b00));  // payload gaps
            usr_fifo_data   <= (fifo_q.size() != 0) ? fifo_q[0] : 32'h0;
        end
    end

    always @(posedge clk)
    begin
        logic [7:0] want;
        cycles = cycles + 1;
        if (cycles >= cycle_limit)
        begin
            $display("timeout after %0d cycles, %0d user words unread", cycles, fifo_q.size());
            stop_failed();
        end
        else if (rst_n && usr_fifo_read && usr_fifo_empty)
        begin
            $display("user FIFO read while it was empty at %0t", $time);
            stop_failed();
        end
        else if (rst_n)
        begin
            for (int i = 0; i < lane_count; i++)
            begin
                if (lanes_fifo_write[i] && lanes_fifo_full[i])
                begin
                    $display("lane %0d written while full at %0t", i, $time);
                    stop_failed();
                end
                else if (lanes_fifo_write[i] && (exp_q[i].size() == 0))
                begin
                    $display("lane %0d wrote a byte that was not expected at %0t", i, $time);
                    stop_failed();
                end
                else if (lanes_fifo_write[i])
                begin
                    want = exp_q[i].pop_front();
                    check_equal(lanes_fifo_data[i*8 +: 8], want, $sformatf("lane %0d byte", i));
                end
            end
        end
    end

    initial
    begin
        int          ln;
        int          used;
        logic [5:0]  dt;
        logic [15:0] field;
        rst_n        = 1'b0;
        lines_number = 3'd1;
        stress       = 1'b0;
        pkt_state    = 32'd57;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        repeat (20) @(posedge clk);  // idle so nothing may move
        for (int g = 0; g < groups; g++)
        begin
            @(negedge clk);
            pkt_state = lcg_step(pkt_state);
            if (g < 8)
                ln = (g % 4) + 1;
            else
                ln = int'(pkt_state[18:16]) % 5;  // 0 acts as one lane
            used   = (ln == 0) ? 1 : ln;
            stress = (g >= 4);
            @(posedge clk);
            lines_number <= 3'(ln);
            repeat (2) @(posedge clk);
            @(negedge clk);
            for (int p = 0; p < packets; p++)
            begin
                pkt_state = lcg_step(pkt_state);
                dt        = pkt_state[21:16];
                pkt_state = lcg_step(pkt_state);
                field     = pkt_state[31:16];
                if (p == 0)
                begin
                    dt    = 6'h29;  // long with empty payload
                    field = 16'h0000;
                end
                else if (p == 1)
                    dt = 6'h05;
                queue_packet(dt, field, used);
            end
            while (work_left())
                @(negedge clk);
            repeat (4) @(negedge clk);
        end
        stress = 1'b0;
        repeat (8) @(negedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
